// File: audio_recorder_top.f
+incdir+dv
rtl/audio_pkg.sv
rtl/codec_pkg.sv
rtl/debounce.sv
rtl/volume_control.sv
rtl/codec_command_seq.sv
rtl/fir_lowpass.sv
rtl/sample_memory.sv
rtl/record_playback.sv
rtl/audio_recorder_top.sv
dv/tb_audio_recorder.sv

// File: dv/tb_models.svh
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

////////////////////////////////////////////////////////////////////////////
// reference state, mirrors what the recorder should hold
////////////////////////////////////////////////////////////////////////////

int       m_volume;
int       m_step;
logic     m_play;
logic     m_filter;
int       m_phase;
int       m_addr;
// count of stored samples, playback wraps here
int       m_end;
sample_t  m_speaker;
sample_t  m_mem [MEM_DEPTH];
// newest input at index 0
sample_t  m_hist [FIR_TAPS];
fir_acc_t m_fir_y;

function automatic void model_reset();
  m_volume  = 8;
  m_step    = 0;
  m_play    = 1'b0;
  m_filter  = 1'b0;
  m_phase   = 0;
  m_addr    = 0;
  m_end     = 0;
  m_speaker = '0;
  m_fir_y   = '0;
  for (int k = 0; k < FIR_TAPS; k++)
    m_hist[k] = '0;
endfunction

// either mode restarts at the first address, record also forgets the old take
function automatic void model_mode_entry(input logic play);
  m_play  = play;
  m_phase = 0;
  m_addr  = 0;
  if (!play)
    m_end = 0;
endfunction

// floor division by 2**shift, kept to the low 8 bits
function automatic sample_t scale_result(input fir_acc_t y, input int shift);
  int wide;
  wide = y;
  return sample_t'(wide >>> shift);
endfunction

// direct-form sum over the coefficient table, wrapped to 18 bits
function automatic void fir_model_strobe(input sample_t x);
  int sum;
  for (int k = FIR_TAPS - 1; k > 0; k--)
    m_hist[k] = m_hist[k-1];
  m_hist[0] = x;
  sum = 0;
  for (int k = 0; k < FIR_TAPS; k++)
    sum += int'(FIR_COEFFS[k]) * int'(m_hist[k]);
  m_fir_y = fir_acc_t'(sum);
endfunction

// one strobe through the recorder, returns the expected speaker sample
function automatic sample_t recorder_model_strobe(input sample_t mic);
  fir_acc_t prev_y;
  sample_t fir_in;
  // the result of the previous strobe is the one the recorder sees
  prev_y = m_fir_y;
  if (!m_filter)
    fir_in = '0;
  else if (!m_play)
    fir_in = mic;
  else if (m_phase == 0)
    fir_in = m_mem[m_addr];
  else
    fir_in = '0;
  if (!m_play) begin
    m_speaker = mic;
    if (m_phase == 0 && m_end < MEM_DEPTH) begin
      // filtered takes are divided by 1024
      m_mem[m_addr] = m_filter ? scale_result(prev_y, 10) : mic;
      m_end = m_addr + 1;
      m_addr = m_end % MEM_DEPTH;
    end
  end else begin
    // zero-stuffed playback is divided by 128
    if (m_filter)
      m_speaker = scale_result(prev_y, 7);
    else if (m_phase == 0)
      m_speaker = m_mem[m_addr];
    if (m_phase == 0)
      m_addr = (m_addr + 1 >= m_end) ? 0 : m_addr + 1;
  end
  m_phase = (m_phase + 1) % DECIMATION;
  m_step = (m_step + 1) % CMD_SEQ_LEN;
  fir_model_strobe(fir_in);
  return m_speaker;
endfunction

function automatic codec_cmd_t codec_write(input codec_reg_t address, input logic [15:0] data);
  codec_cmd_t cmd;
  cmd.valid   = 1'b1;
  cmd.read    = 1'b0;
  cmd.address = address;
  cmd.data    = data;
  return cmd;
endfunction

// command table, step 3 carries the attenuation in both bytes
function automatic codec_cmd_t expected_cmd(input int step, input int vol);
  codec_cmd_t cmd;
  logic [4:0] atten;
  atten = 5'(31 - vol);
  case (step)
    3:  cmd = codec_write(REG_HEADPHONE_VOL, {3'b000, atten, 3'b000, atten});
    5:  cmd = codec_write(REG_PCM_VOL, 16'h0808);
    6:  cmd = codec_write(REG_RECORD_SELECT, 16'h0000);
    7:  cmd = codec_write(REG_RECORD_GAIN, 16'h0F0F);
    9:  cmd = codec_write(REG_MIC_VOL, 16'h8048);
    10: cmd = codec_write(REG_BEEP_VOL, 16'h0000);
    11: cmd = codec_write(REG_GENERAL, 16'h8000);
    default: begin
      cmd = codec_write(REG_RESET_ID, 16'h0000);
      cmd.read = 1'b1;
    end
  endcase
  return cmd;
endfunction

`endif

// File: dv/tb_audio_recorder.sv
`default_nettype none

module tb_audio_recorder import audio_pkg::*; import codec_pkg::*;;

  localparam int CLOCK_PERIOD  = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int TB_DEBOUNCE   = 16;
  localparam int TB_ADDR_WIDTH = 6;
  localparam int MEM_DEPTH     = 2**TB_ADDR_WIDTH;
  // clocks from one strobe to the next
  localparam int STROBE_PERIOD = 40;
  // well past the 17 clock debounce window
  localparam int PRESS_CLOCKS  = 24;
  localparam int SETTLE_CLOCKS = 40;
  localparam int PRESS_COUNT   = 63;
  localparam int FILL_STROBES  = MEM_DEPTH * DECIMATION;
  // one more group once the memory is full, which must not be stored
  localparam int RECORD_STROBES = FILL_STROBES + DECIMATION;
  // the 3 samples left by the codec rounds played once and then one more
  localparam int SHORT_PLAY_STROBES = 4 * DECIMATION;
  // a full loop plus two more stored samples
  localparam int LOOP_STROBES  = FILL_STROBES + 2 * DECIMATION;
  localparam int TOTAL_STROBES = 2 * CMD_SEQ_LEN + SHORT_PLAY_STROBES + 2 * RECORD_STROBES
                               + FILL_STROBES + 2 * LOOP_STROBES;
  localparam int TIMEOUT_CYCLES = TOTAL_STROBES * STROBE_PERIOD
                                + PRESS_COUNT * 2 * PRESS_CLOCKS + 10000;

  logic                    clock;
  logic                    reset;
  logic                    sample_strobe;
  sample_t                 mic_sample;
  logic                    button_up;
  logic                    button_down;
  logic                    button_play;
  logic                    switch_filter;
  sample_t                 speaker_sample;
  logic [VOLUME_WIDTH-1:0] volume;
  codec_cmd_t              codec_cmd;

  integer seed;
  int errors;
  int cycle_count = 0;

  `include "tb_models.svh"

  audio_recorder_top #(
    .DEBOUNCE_CYCLES (TB_DEBOUNCE),
    .ADDR_WIDTH      (TB_ADDR_WIDTH)
  ) u_dut (
    .clock          (clock),
    .reset          (reset),
    .sample_strobe  (sample_strobe),
    .mic_sample     (mic_sample),
    .button_up      (button_up),
    .button_down    (button_down),
    .button_play    (button_play),
    .switch_filter  (switch_filter),
    .speaker_sample (speaker_sample),
    .volume         (volume),
    .codec_cmd      (codec_cmd)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // hard stop if the sequence below stalls
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // inputs move just after the rising edge
  task automatic step_clock();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic sample_t random_sample();
    return sample_t'($random(seed));
  endfunction

  // one strobe with the speaker checked a clock later and the command before the next one
  task automatic strobe_sample(input sample_t mic);
    sample_t expected;
    mic_sample    = mic;
    sample_strobe = 1'b1;
    step_clock();
    sample_strobe = 1'b0;
    expected = recorder_model_strobe(mic);
    check_value("speaker_sample", speaker_sample, expected);
    repeat (STROBE_PERIOD - 1) step_clock();
    check_value("codec_cmd", codec_cmd, expected_cmd(m_step, m_volume));
  endtask

  // a press and release of one or both buttons where down wins over up
  task automatic press_buttons(input logic up, input logic down);
    button_up   = up;
    button_down = down;
    repeat (PRESS_CLOCKS) step_clock();
    button_up   = 1'b0;
    button_down = 1'b0;
    repeat (PRESS_CLOCKS) step_clock();
    if (down)
      m_volume = (m_volume > 0) ? m_volume - 1 : 0;
    else if (up)
      m_volume = (m_volume < 31) ? m_volume + 1 : 31;
    check_value("volume", volume, m_volume);
  endtask

  // pulses shorter than the debounce window
  task automatic glitch_controls();
    button_up     = 1'b1;
    button_down   = 1'b1;
    button_play   = 1'b1;
    switch_filter = 1'b1;
    repeat (12) step_clock();
    button_up     = 1'b0;
    button_down   = 1'b0;
    button_play   = 1'b0;
    switch_filter = 1'b0;
    repeat (SETTLE_CLOCKS) step_clock();
    check_value("volume", volume, m_volume);
  endtask

  task automatic set_play(input logic level);
    button_play = level;
    repeat (SETTLE_CLOCKS) step_clock();
    model_mode_entry(level);
  endtask

  task automatic set_filter(input logic level);
    switch_filter = level;
    repeat (SETTLE_CLOCKS) step_clock();
    m_filter = level;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test order
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 47289;
    errors        = 0;
    reset         = 1'b1;
    sample_strobe = 1'b0;
    mic_sample    = '0;
    button_up     = 1'b0;
    button_down   = 1'b0;
    button_play   = 1'b0;
    switch_filter = 1'b0;
    model_reset();
    repeat (3) step_clock();
    reset = 1'b0;
    step_clock();

    // reset state
    check_value("volume", volume, m_volume);
    check_value("speaker_sample", speaker_sample, 0);
    check_value("codec_cmd", codec_cmd, expected_cmd(0, m_volume));

    // saturate at the top and then at the bottom to end at 3
    repeat (25) press_buttons(1'b1, 1'b0);
    repeat (33) press_buttons(1'b0, 1'b1);
    repeat (4) press_buttons(1'b1, 1'b0);
    press_buttons(1'b1, 1'b1);
    glitch_controls();

    // two rounds of the codec list
    repeat (2 * CMD_SEQ_LEN) strobe_sample(random_sample());

    // the short take from the codec rounds wraps at its end marker
    set_play(1'b1);
    repeat (SHORT_PLAY_STROBES) strobe_sample(random_sample());

    // record a fresh unfiltered take past full and loop over it
    set_play(1'b0);
    repeat (RECORD_STROBES) strobe_sample(random_sample());
    set_play(1'b1);
    repeat (LOOP_STROBES) strobe_sample(random_sample());

    // record a filtered take and read it back raw and then through the filter
    set_filter(1'b1);
    set_play(1'b0);
    repeat (RECORD_STROBES) strobe_sample(random_sample());
    set_filter(1'b0);
    set_play(1'b1);
    repeat (FILL_STROBES) strobe_sample(random_sample());
    set_filter(1'b1);
    repeat (LOOP_STROBES) strobe_sample(random_sample());

    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/audio_recorder_top.sv
`default_nettype none

module audio_recorder_top import audio_pkg::*; import codec_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = 270000,
  parameter int ADDR_WIDTH      = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    sample_strobe,
  input  sample_t                 mic_sample,
  input  logic                    button_up,
  input  logic                    button_down,
  input  logic                    button_play,
  input  logic                    switch_filter,
  output sample_t                 speaker_sample,
  output logic [VOLUME_WIDTH-1:0] volume,
  output codec_cmd_t              codec_cmd
);

  // debounced mode controls
  logic play_clean;
  logic filter_clean;
  // filter and memory hookup
  sample_t fir_x;
  fir_acc_t fir_y;
  logic mem_write_en;
  logic [ADDR_WIDTH-1:0] mem_address;
  sample_t mem_write_data;
  sample_t mem_read_data;

  volume_control #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_volume (
    .clock (clock), .reset (reset),
    .button_up (button_up), .button_down (button_down), .volume (volume)
  );

  // playback while the clean level is high and record while it is low
  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_play_debounce (
    .clock (clock), .reset (reset), .noisy (button_play), .clean (play_clean)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_filter_debounce (
    .clock (clock), .reset (reset), .noisy (switch_filter), .clean (filter_clean)
  );

  codec_command_seq u_codec_seq (
    .clock (clock), .reset (reset), .sample_strobe (sample_strobe),
    .volume (volume), .codec_cmd (codec_cmd)
  );

  fir_lowpass u_fir (
    .clock (clock), .reset (reset), .sample_strobe (sample_strobe), .x (fir_x), .y (fir_y)
  );

  sample_memory #(.ADDR_WIDTH(ADDR_WIDTH)) u_memory (
    .clock (clock), .write_en (mem_write_en), .address (mem_address),
    .write_data (mem_write_data), .read_data (mem_read_data)
  );

  record_playback #(.ADDR_WIDTH(ADDR_WIDTH)) u_recorder (
    .clock (clock), .reset (reset), .sample_strobe (sample_strobe),
    .playback (play_clean), .filter_en (filter_clean),
    .mic_sample (mic_sample), .fir_y (fir_y), .mem_read_data (mem_read_data),
    .fir_x (fir_x), .mem_write_en (mem_write_en), .mem_address (mem_address),
    .mem_write_data (mem_write_data), .speaker_sample (speaker_sample)
  );

endmodule

`default_nettype wire

// File: rtl/record_playback.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// record: decimate by 8 into memory
// playback: loop over the recording, hold or zero-stuff each sample
////////////////////////////////////////////////////////////////////////////

module record_playback import audio_pkg::*; #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  sample_strobe,
  input  logic                  playback,
  input  logic                  filter_en,
  input  sample_t               mic_sample,
  input  fir_acc_t              fir_y,
  input  sample_t               mem_read_data,
  output sample_t               fir_x,
  output logic                  mem_write_en,
  output logic [ADDR_WIDTH-1:0] mem_address,
  output sample_t               mem_write_data,
  output sample_t               speaker_sample
);

  localparam int PHASE_WIDTH = $clog2(DECIMATION);

  // position within the current group of 8 strobes
  logic [PHASE_WIDTH-1:0] phase;
  logic [ADDR_WIDTH-1:0] address;
  // one past the last recorded address, msb set once the memory is full
  logic [ADDR_WIDTH:0] end_marker;
  logic [ADDR_WIDTH:0] next_address;
  // mode seen on the previous clock
  logic play_mode;
  logic mode_entry;
  logic rec_strobe;
  logic play_strobe;
  logic mem_full;
  logic phase_zero;
  sample_t rec_filtered;
  sample_t play_filtered;

  assign mode_entry   = playback != play_mode;
  // a strobe landing on a mode change is spent on the entry
  assign rec_strobe   = sample_strobe & ~mode_entry & ~playback;
  assign play_strobe  = sample_strobe & ~mode_entry & playback;
  assign mem_full     = end_marker[ADDR_WIDTH];
  assign phase_zero   = phase == '0;
  assign next_address = {1'b0, address} + 1'b1;

  // scale the 18-bit filter result back to a sample
  assign rec_filtered  = fir_y[REC_FILTER_SHIFT +: SAMPLE_WIDTH];
  assign play_filtered = fir_y[PLAY_FILTER_SHIFT +: SAMPLE_WIDTH];

  // memory port
  assign mem_address    = address;
  assign mem_write_en   = rec_strobe & phase_zero & ~mem_full;
  assign mem_write_data = filter_en ? rec_filtered : mic_sample;

  // filter feed: live mic when recording, zero-stuffed memory on playback
  always_comb begin
    if (!filter_en)
      fir_x = '0;
    else if (!playback)
      fir_x = mic_sample;
    else
      fir_x = phase_zero ? mem_read_data : '0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      play_mode      <= 1'b0;
      phase          <= '0;
      address        <= '0;
      end_marker     <= '0;
      speaker_sample <= '0;
    end else begin
      play_mode <= playback;
      if (mode_entry) begin
        phase   <= '0;
        address <= '0;
        // a new recording starts empty
        if (!playback)
          end_marker <= '0;
      end else if (sample_strobe) begin
        phase <= (phase == PHASE_WIDTH'(DECIMATION - 1)) ? '0 : phase + 1'b1;
      end

      if (rec_strobe) begin
        // monitor the mic while recording
        speaker_sample <= mic_sample;
        if (mem_write_en) begin
          address    <= next_address[ADDR_WIDTH-1:0];
          end_marker <= next_address;
        end
      end

      if (play_strobe) begin
        if (filter_en)
          speaker_sample <= play_filtered;
        else if (phase_zero)
          // held for the following 7 strobes
          speaker_sample <= mem_read_data;
        if (phase_zero)
          address <= (next_address >= end_marker) ? '0 : next_address[ADDR_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_memory.sv
`default_nettype none

module sample_memory import audio_pkg::*; #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clock,
  input  logic                  write_en,
  input  logic [ADDR_WIDTH-1:0] address,
  input  sample_t               write_data,
  output sample_t               read_data
);

  // plain block ram, 2**ADDR_WIDTH samples
  sample_t mem [2**ADDR_WIDTH];

  always_ff @(posedge clock) begin
    if (write_en)
      mem[address] <= write_data;
    // registered read, old data on a write cycle
    read_data <= mem[address];
  end

endmodule

`default_nettype wire

// File: rtl/fir_lowpass.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// serial 31-tap fir, one multiply per clock after each strobe
////////////////////////////////////////////////////////////////////////////

module fir_lowpass import audio_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     sample_strobe,
  input  sample_t  x,
  output fir_acc_t y
);

  // index value once every tap is summed
  localparam logic [FIR_INDEX_WIDTH-1:0] TAPS_DONE = FIR_INDEX_WIDTH'(FIR_TAPS);

  // recent inputs, newest at ring[newest]
  sample_t ring [FIR_RING_DEPTH];
  logic [FIR_INDEX_WIDTH-1:0] newest;
  logic [FIR_INDEX_WIDTH-1:0] index;
  // ring slot paired with the current tap, wraps mod 32
  logic [FIR_INDEX_WIDTH-1:0] tap_ptr;
  coeff_t coeff;
  fir_acc_t acc;
  fir_acc_t product;

  assign tap_ptr = newest - index;
  // idle index points past the table
  assign coeff   = (index < TAPS_DONE) ? FIR_COEFFS[index] : '0;
  assign product = coeff * ring[tap_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      // clear the history so the first results start from silence
      for (int i = 0; i < FIR_RING_DEPTH; i++)
        ring[i] <= '0;
      newest <= '0;
      index  <= TAPS_DONE;
      acc    <= '0;
      y      <= '0;
    end else if (sample_strobe) begin
      // new sample in, restart the sum
      ring[newest + 1'b1] <= x;
      newest <= newest + 1'b1;
      index  <= '0;
      acc    <= '0;
    end else if (index < TAPS_DONE) begin
      // tap k against the sample k strobes back
      acc   <= acc + product;
      index <= index + 1'b1;
    end else begin
      // sum complete, 32 clocks after the strobe
      y <= acc;
    end
  end

  // the strobe spacing must leave room for 31 taps plus the output load
  strobe_after_result: assert property (@(posedge clock) disable iff (reset)
    sample_strobe |-> (index == TAPS_DONE) && ($past(index) == TAPS_DONE));

endmodule

`default_nettype wire

// File: rtl/codec_command_seq.sv
`default_nettype none

module codec_command_seq import audio_pkg::*; import codec_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    sample_strobe,
  input  logic [VOLUME_WIDTH-1:0] volume,
  output codec_cmd_t              codec_cmd
);

  cmd_step_t step;
  codec_cmd_t next_cmd;
  // codec wants attenuation, not gain
  logic [VOLUME_WIDTH-1:0] atten;

  assign atten = 5'd31 - volume;

  ////////////////////////////////////////////////////////////////////////////
  // command list, one entry per step
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (step)
      4'd3:
        next_cmd = write_cmd(REG_HEADPHONE_VOL, {3'b000, atten, 3'b000, atten});
      4'd5:
        next_cmd = write_cmd(REG_PCM_VOL, DATA_PCM_VOL);
      4'd6:
        next_cmd = write_cmd(REG_RECORD_SELECT, DATA_RECORD_MIC);
      4'd7:
        next_cmd = write_cmd(REG_RECORD_GAIN, DATA_RECORD_GAIN);
      4'd9:
        next_cmd = write_cmd(REG_MIC_VOL, DATA_MIC_GAIN);
      4'd10:
        next_cmd = write_cmd(REG_BEEP_VOL, DATA_BEEP_VOL);
      4'd11:
        next_cmd = write_cmd(REG_GENERAL, DATA_GENERAL);
      // steps 0, 1 and the gaps just read the id
      default:
        next_cmd = CMD_READ_ID;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step      <= '0;
      codec_cmd <= CMD_READ_ID;
    end else begin
      // command follows the step one clock behind
      codec_cmd <= next_cmd;
      if (sample_strobe)
        step <= (step == cmd_step_t'(CMD_SEQ_LEN - 1)) ? '0 : step + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/volume_control.sv
`default_nettype none

module volume_control import audio_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    button_up,
  input  logic                    button_down,
  output logic [VOLUME_WIDTH-1:0] volume
);

  logic up_clean;
  logic down_clean;
  // clean levels one clock back, for edge detection
  logic up_prev;
  logic down_prev;
  logic up_rise;
  logic down_rise;

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_up_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_up),
    .clean (up_clean)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_down_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (button_down),
    .clean (down_clean)
  );

  assign up_rise   = up_clean & ~up_prev;
  assign down_rise = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    // track the clean levels in reset too, a held button is no press
    up_prev   <= up_clean;
    down_prev <= down_clean;
    if (reset) begin
      volume <= VOLUME_RESET;
    end else if (down_rise) begin
      // down has priority when both rise together
      if (volume != '0)
        volume <= volume - 1'b1;
    end else if (up_rise) begin
      if (volume != '1)
        volume <= volume + 1'b1;
    end
  end

  // single steps only, whatever the buttons do
  volume_single_step: assert property (@(posedge clock) disable iff (reset)
    (volume != $past(volume)) |->
      (volume == $past(volume) + 1'b1) || (volume == $past(volume) - 1'b1));

endmodule

`default_nettype wire

// File: rtl/debounce.sv
`default_nettype none

module debounce #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

  logic [COUNT_WIDTH-1:0] count;
  // last sampled level of the noisy input
  logic last;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      last  <= noisy;
      clean <= noisy;
    end else if (noisy != last) begin
      // input moved, start the stability window again
      last  <= noisy;
      count <= '0;
    end else if (count == COUNT_WIDTH'(DEBOUNCE_CYCLES)) begin
      // held long enough, pass it on
      clean <= last;
    end else begin
      count <= count + 1'b1;
    end
  end

  // the clean level only ever moves when a full window has elapsed
  clean_on_window_end: assert property (@(posedge clock) disable iff (reset)
    $changed(clean) |-> $past(reset) || ($past(count) == COUNT_WIDTH'(DEBOUNCE_CYCLES)));

endmodule

`default_nettype wire

// File: rtl/codec_pkg.sv
`default_nettype none

package codec_pkg;

  typedef logic [7:0] codec_reg_t;

  // one codec register access, 26 bits
  typedef struct packed {
    logic       valid;
    logic       read;
    codec_reg_t address;
    logic [15:0] data;
  } codec_cmd_t;

  // length of the repeating command list and its step counter
  parameter int CMD_SEQ_LEN = 12;
  typedef logic [3:0] cmd_step_t;

  // codec register map
  parameter codec_reg_t REG_RESET_ID      = 8'h00;
  parameter codec_reg_t REG_HEADPHONE_VOL = 8'h04;
  parameter codec_reg_t REG_BEEP_VOL      = 8'h0A;
  parameter codec_reg_t REG_MIC_VOL       = 8'h0E;
  parameter codec_reg_t REG_PCM_VOL       = 8'h18;
  parameter codec_reg_t REG_RECORD_SELECT = 8'h1A;
  parameter codec_reg_t REG_RECORD_GAIN   = 8'h1C;
  parameter codec_reg_t REG_GENERAL       = 8'h20;

  // data words of the fixed commands
  parameter logic [15:0] DATA_PCM_VOL     = 16'h0808;
  // source 000 in both channels selects the microphone
  parameter logic [15:0] DATA_RECORD_MIC  = 16'h0000;
  parameter logic [15:0] DATA_RECORD_GAIN = 16'h0F0F;
  // +20 dB boost on the mic input
  parameter logic [15:0] DATA_MIC_GAIN    = 16'h8048;
  parameter logic [15:0] DATA_BEEP_VOL    = 16'h0000;
  // pcm out bypasses mix1
  parameter logic [15:0] DATA_GENERAL     = 16'h8000;

  // idle filler command, reads the vendor id register
  parameter codec_cmd_t CMD_READ_ID = '{
    valid: 1'b1, read: 1'b1, address: REG_RESET_ID, data: 16'h0000
  };

  function automatic codec_cmd_t write_cmd(codec_reg_t address, logic [15:0] data);
    return '{valid: 1'b1, read: 1'b0, address: address, data: data};
  endfunction

endpackage

`default_nettype wire

// File: rtl/audio_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// sample path widths, types and filter constants
////////////////////////////////////////////////////////////////////////////

package audio_pkg;

  // 8-bit signed pcm samples to and from the codec
  parameter int SAMPLE_WIDTH = 8;
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // fir coefficients are scaled by 1024, so the product grows to 18 bits
  parameter int COEFF_WIDTH = 10;
  parameter int PRODUCT_WIDTH = SAMPLE_WIDTH + COEFF_WIDTH;
  typedef logic signed [COEFF_WIDTH-1:0] coeff_t;
  typedef logic signed [PRODUCT_WIDTH-1:0] fir_acc_t;

  // 31 taps, history ring of 32 entries addressed by 5 bits
  parameter int FIR_TAPS = 31;
  parameter int FIR_RING_DEPTH = 32;
  parameter int FIR_INDEX_WIDTH = $clog2(FIR_RING_DEPTH);

  // low pass with cutoff at 1/8 of nyquist, round(fir1(30, .125) * 1024)
  parameter coeff_t FIR_COEFFS [FIR_TAPS] = '{
    -1, -1, -3, -5, -6, -7, -5, 0, 10, 26, 46, 69, 91, 110, 123,
    128,
    123, 110, 91, 69, 46, 26, 10, 0, -5, -7, -6, -5, -3, -1, -1
  };

  // filter result back to 8 bits: /1024 when recording,
  // /128 on zero-stuffed playback to make up the lost gain of 8
  parameter int REC_FILTER_SHIFT = 10;
  parameter int PLAY_FILTER_SHIFT = 7;

  // strobes per stored sample
  parameter int DECIMATION = 8;

  // headphone volume, 0 is quietest
  parameter int VOLUME_WIDTH = 5;
  parameter logic [VOLUME_WIDTH-1:0] VOLUME_RESET = 5'd8;

endpackage

`default_nettype wire
